// ==== design/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane (
    input  logic               clk,
    input  logic               reset,
    input  wb_pkg::alu_issue_t issue,
    output wb_pkg::wb_data_t   wb
);

    logic [wb_pkg::xlen-1:0] res;
    logic                    legal;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign lt_signed   = $signed(issue.src_a) < $signed(issue.src_b);
    assign lt_unsigned = issue.src_a < issue.src_b;

    always_comb begin
        legal = 1'b1;
        res   = '0;
        case (issue.op)
            wb_pkg::op_add: begin
                res = issue.src_a + issue.src_b;
            end
            wb_pkg::op_sub: begin
                res = issue.src_a - issue.src_b;
            end
            wb_pkg::op_and: begin
                res = issue.src_a & issue.src_b;
            end
            wb_pkg::op_or: begin
                res = issue.src_a | issue.src_b;
            end
            wb_pkg::op_xor: begin
                res = issue.src_a ^ issue.src_b;
            end
            wb_pkg::op_slt: begin
                res = {{(wb_pkg::xlen-1){1'b0}}, lt_signed};
            end
            wb_pkg::op_sltu: begin
                res = {{(wb_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            default: begin
                // unused opcode, result stays zero.
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.en <= 1'b0;
        end else begin
            wb.en <= issue.valid;
        end
    end

    // payload of the registered entry.
    always_ff @(posedge clk) begin
        wb.we      <= legal;
        wb.rob_idx <= issue.rob_idx;
        wb.rd      <= issue.rd;
        wb.res     <= res;
        wb.exccode <= legal ? wb_pkg::exc_none : wb_pkg::exc_illegal;
    end

endmodule

// ==== design/exec_wb_top.sv ====
`timescale 1ns/1ps

module exec_wb_top (
    input  logic               clk,
    input  logic               reset,
    input  wb_pkg::alu_issue_t alu_issue,
    input  wb_pkg::mul_issue_t mul_issue,
    output wb_pkg::wb_data_t   wb_bus,
    output logic               mul_issue_credit
);

    wb_pkg::wb_data_t alu_wb;
    wb_pkg::wb_data_t mul_wb;
    logic             wb_credit;

    alu_lane alu_lane_i (
        .clk   (clk),
        .reset (reset),
        .issue (alu_issue),
        .wb    (alu_wb)
    );

    mul_unit mul_unit_i (
        .clk          (clk),
        .reset        (reset),
        .issue        (mul_issue),
        .wb_credit    (wb_credit),
        .wb           (mul_wb),
        .issue_credit (mul_issue_credit)
    );

    // single writeback port, ALU first.
    wb_merge wb_merge_i (
        .clk       (clk),
        .reset     (reset),
        .alu_wb    (alu_wb),
        .mul_wb    (mul_wb),
        .wb_credit (wb_credit),
        .wb_bus    (wb_bus)
    );

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
    input  logic               clk,
    input  logic               reset,
    input  wb_pkg::mul_issue_t issue,
    input  logic               wb_credit,
    output wb_pkg::wb_data_t   wb,
    output logic               issue_credit
);

    typedef struct packed {
        logic                         high;
        logic [wb_pkg::rob_idx_w-1:0] rob_idx;
        logic [wb_pkg::reg_idx_w-1:0] rd;
        logic [2*wb_pkg::xlen-1:0]    prod;
    } mul_stage_t;

    // the queue write acts as the last pipeline stage.
    logic [wb_pkg::mul_stages-2:0] stage_valid;
    mul_stage_t                    stage [wb_pkg::mul_stages-1];
    mul_stage_t                    last;

    wb_pkg::wb_data_t              done;
    wb_pkg::wb_data_t              queue [wb_pkg::mul_queue_depth];
    logic [wb_pkg::mul_ptr_w-1:0]  wr_ptr;
    logic [wb_pkg::mul_ptr_w-1:0]  rd_ptr;
    logic [wb_pkg::mul_cnt_w-1:0]  count;
    logic [wb_pkg::wb_cnt_w-1:0]   credits;
    logic                          push;
    logic                          pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[wb_pkg::mul_stages-3:0], issue.valid};
        end
    end

    always_ff @(posedge clk) begin
        stage[0].high    <= issue.high;
        stage[0].rob_idx <= issue.rob_idx;
        stage[0].rd      <= issue.rd;
        stage[0].prod    <= issue.src_a * issue.src_b;
        for (int i = 1; i < wb_pkg::mul_stages - 1; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign last = stage[wb_pkg::mul_stages-2];
    assign push = stage_valid[wb_pkg::mul_stages-2];

    // pick the requested half of the product.
    always_comb begin
        done.en      = 1'b1;
        done.we      = 1'b1;
        done.rob_idx = last.rob_idx;
        done.rd      = last.rd;
        done.res     = last.high ? last.prod[2*wb_pkg::xlen-1:wb_pkg::xlen]
                                 : last.prod[wb_pkg::xlen-1:0];
        done.exccode = wb_pkg::exc_none;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= done;
        end
    end

    // head may leave only while a writeback credit is held.
    assign pop = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= wb_pkg::wb_cnt_w'(wb_pkg::wb_buf_depth);
        end else begin
            wr_ptr  <= wr_ptr + push;
            rd_ptr  <= rd_ptr + pop;
            count   <= count + push - pop;
            credits <= credits + wb_credit - pop;
        end
    end

    always_comb begin
        wb    = queue[rd_ptr];
        wb.en = pop;
    end

    assign issue_credit = pop;

endmodule

// ==== design/wb_merge.sv ====
`timescale 1ns/1ps

module wb_merge (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::wb_data_t alu_wb,
    input  wb_pkg::wb_data_t mul_wb,
    output logic             wb_credit,
    output wb_pkg::wb_data_t wb_bus
);

    wb_pkg::wb_data_t             buffer [wb_pkg::wb_buf_depth];
    logic [wb_pkg::wb_ptr_w-1:0]  wr_ptr;
    logic [wb_pkg::wb_ptr_w-1:0]  rd_ptr;
    logic [wb_pkg::wb_cnt_w-1:0]  count;
    logic                         drain;

    // buffered entries only use slots the ALU leaves empty.
    assign drain     = !alu_wb.en && (count != '0);
    assign wb_credit = drain;

    always_ff @(posedge clk) begin
        if (mul_wb.en) begin
            buffer[wr_ptr] <= mul_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + mul_wb.en;
            rd_ptr <= rd_ptr + drain;
            count  <= count + mul_wb.en - drain;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_bus.en <= 1'b0;
        end else if (alu_wb.en) begin
            wb_bus <= alu_wb;
        end else if (drain) begin
            wb_bus <= buffer[rd_ptr];
        end else begin
            wb_bus.en <= 1'b0;
        end
    end

endmodule

// ==== design/wb_pkg.sv ====
package wb_pkg;

    localparam int xlen      = 32;
    localparam int rob_idx_w = 6;
    localparam int reg_idx_w = 5;
    localparam int exc_w     = 4;

    localparam logic [exc_w-1:0] exc_none    = 4'd0;
    localparam logic [exc_w-1:0] exc_illegal = 4'd2;

    localparam int mul_stages      = 3;
    localparam int mul_queue_depth = 4;
    localparam int wb_buf_depth    = 2;

    // queue and buffer bookkeeping widths.
    localparam int mul_ptr_w = $clog2(mul_queue_depth);
    localparam int mul_cnt_w = $clog2(mul_queue_depth + 1);
    localparam int wb_ptr_w  = $clog2(wb_buf_depth);
    localparam int wb_cnt_w  = $clog2(wb_buf_depth + 1);

    // code 7 is left unused and decodes as illegal.
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5,
        op_sltu = 3'd6
    } alu_op_t;

    typedef struct packed {
        logic                 valid;
        alu_op_t              op;
        logic [rob_idx_w-1:0] rob_idx;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      src_a;
        logic [xlen-1:0]      src_b;
    } alu_issue_t;

    typedef struct packed {
        logic                 valid;
        logic                 high;
        logic [rob_idx_w-1:0] rob_idx;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      src_a;
        logic [xlen-1:0]      src_b;
    } mul_issue_t;

    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [rob_idx_w-1:0] rob_idx;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      res;
        logic [exc_w-1:0]     exccode;
    } wb_data_t;

endpackage

// ==== dv/exec_wb_tb_ref.svh ====
`ifndef EXEC_WB_TB_REF_SVH
`define EXEC_WB_TB_REF_SVH

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// expected writeback entry for an ALU issue.
function automatic wb_pkg::wb_data_t expected_alu(input wb_pkg::alu_issue_t issue);
    wb_pkg::wb_data_t e;
    int               sa;
    int               sb;
    sa = issue.src_a;
    sb = issue.src_b;
    e = '0;
    e.en = 1'b1;
    e.we = 1'b1;
    e.rob_idx = issue.rob_idx;
    e.rd = issue.rd;
    e.exccode = wb_pkg::exc_none;
    case (3'(issue.op))
        3'd0: e.res = issue.src_a + issue.src_b;
        3'd1: e.res = issue.src_a + ~issue.src_b + 32'd1;
        3'd2: e.res = issue.src_a & issue.src_b;
        3'd3: e.res = issue.src_a | issue.src_b;
        3'd4: e.res = issue.src_a ^ issue.src_b;
        3'd5: e.res = (sa < sb) ? 32'd1 : 32'd0;
        3'd6: e.res = ({1'b0, issue.src_a} < {1'b0, issue.src_b}) ? 32'd1 : 32'd0;
        default: begin
            e.we = 1'b0;
            e.res = '0;
            e.exccode = wb_pkg::exc_illegal;
        end
    endcase
    return e;
endfunction

// expected writeback entry for a multiply, low or high half.
function automatic wb_pkg::wb_data_t expected_mul(input wb_pkg::mul_issue_t issue);
    wb_pkg::wb_data_t e;
    logic [63:0]      prod;
    prod = {32'd0, issue.src_a} * {32'd0, issue.src_b};
    e = '0;
    e.en = 1'b1;
    e.we = 1'b1;
    e.rob_idx = issue.rob_idx;
    e.rd = issue.rd;
    e.res = issue.high ? prod[63:32] : prod[31:0];
    e.exccode = wb_pkg::exc_none;
    return e;
endfunction

task automatic check_wb(input string name, input wb_pkg::wb_data_t got,
                        input wb_pkg::wb_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

task automatic check_credits(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
    end
endtask

`endif

// ==== dv/exec_wb_tb.sv ====
`timescale 1ns/1ps

module exec_wb_tb;

    localparam int n_alu_per_op = 10;
    localparam int n_illegal    = 4;
    localparam int n_mul_iso    = 8;
    localparam int n_mul_group  = 4;
    localparam int mixed_cycles = 60;
    localparam int burst_cycles = 40;
    localparam int total_issues = 7 * n_alu_per_op + n_illegal + n_mul_iso + n_mul_group
                                  + 2 * mixed_cycles + 2 * burst_cycles;
    localparam int cycle_limit  = total_issues * 4 + 200;
    localparam int n_tags       = 1 << wb_pkg::rob_idx_w;

    logic               clk;
    logic               reset;
    wb_pkg::alu_issue_t alu_issue;
    wb_pkg::mul_issue_t mul_issue;
    wb_pkg::wb_data_t   wb_bus;
    logic               mul_issue_credit;

    logic [31:0]        lcg_state = 32'h2b9ec979;
    int                 cycle = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 tests = 0;
    int                 test_start_errors = 0;
    int                 credits = wb_pkg::mul_queue_depth;
    bit                 in_burst = 1'b0;

    // expected entries in flight by rob tag.
    wb_pkg::wb_data_t   pending [int];
    bit                 is_mul [int];
    int                 issue_cycle [int];
    int                 mul_order [$];

    `include "exec_wb_tb_ref.svh"

    exec_wb_top exec_wb_top_i (
        .clk              (clk),
        .reset            (reset),
        .alu_issue        (alu_issue),
        .mul_issue        (mul_issue),
        .wb_bus           (wb_bus),
        .mul_issue_credit (mul_issue_credit)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("ERROR: run stopped after %0d cycles with %0d entries never written back",
                     cycle, pending.num());
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int alloc_tag();
        int tag;
        tag = (next_rand() >> 8) % n_tags;
        while (pending.exists(tag)) begin
            tag = (tag + 1) % n_tags;
        end
        return tag;
    endfunction

    // one clock of stimulus just after the edge.
    task automatic drive_cycle(input bit do_alu, input logic [2:0] op,
                               input bit do_mul, input bit high);
        wb_pkg::alu_issue_t a;
        wb_pkg::mul_issue_t m;
        int                 tag;
        @(posedge clk);
        #1;
        a = '0;
        m = '0;
        if (do_alu) begin
            tag = alloc_tag();
            a.valid = 1'b1;
            a.op = wb_pkg::alu_op_t'(op);
            a.rob_idx = wb_pkg::rob_idx_w'(tag);
            a.rd = wb_pkg::reg_idx_w'(next_rand());
            a.src_a = next_rand();
            a.src_b = next_rand();
            pending[tag] = expected_alu(a);
            is_mul[tag] = 1'b0;
            issue_cycle[tag] = cycle;
        end
        if (do_mul && credits > 0) begin
            tag = alloc_tag();
            m.valid = 1'b1;
            m.high = high;
            m.rob_idx = wb_pkg::rob_idx_w'(tag);
            m.rd = wb_pkg::reg_idx_w'(next_rand());
            m.src_a = next_rand();
            m.src_b = next_rand();
            pending[tag] = expected_mul(m);
            is_mul[tag] = 1'b1;
            issue_cycle[tag] = cycle;
            mul_order.push_back(tag);
            credits--;
        end
        alu_issue = a;
        mul_issue = m;
    endtask

    task automatic wait_drain();
        drive_cycle(1'b0, 3'd0, 1'b0, 1'b0);
        while (pending.num() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic check_result();
        int tag;
        tag = wb_bus.rob_idx;
        if (!pending.exists(tag)) begin
            errors++;
            $display("ERROR: t=%0t result with rob tag %0d that is not in flight", $time, tag);
        end else begin
            check_wb("wb_bus", wb_bus, pending[tag]);
            if (is_mul[tag]) begin
                if (in_burst) begin
                    errors++;
                    $display("ERROR: t=%0t multiply result on wb_bus during ALU burst", $time);
                end
                check_latency("mul order tag", tag, mul_order.size() ? mul_order[0] : -1);
                if (mul_order.size() != 0) begin
                    void'(mul_order.pop_front());
                end
            end else begin
                check_latency("alu latency", cycle - issue_cycle[tag], 2);
            end
            pending.delete(tag);
        end
    endtask

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (!reset) begin
            if (mul_issue_credit) begin
                credits++;
            end
            if (wb_bus.en) begin
                check_result();
            end
        end
    end

    initial begin
        reset = 1'b1;
        alu_issue = '0;
        mul_issue = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_flag("wb_bus.en", wb_bus.en, 1'b0);
            check_flag("mul_issue_credit", mul_issue_credit, 1'b0);
        end
        report_test("reset_state");

        for (int op = 0; op < 7; op++) begin
            for (int i = 0; i < n_alu_per_op; i++) begin
                drive_cycle(1'b1, 3'(op), 1'b0, 1'b0);
            end
        end
        wait_drain();
        report_test("alu_ops");

        for (int i = 0; i < n_illegal; i++) begin
            drive_cycle(1'b1, 3'd7, 1'b0, 1'b0);
        end
        wait_drain();
        report_test("illegal_op");

        for (int i = 0; i < n_mul_iso; i++) begin
            drive_cycle(1'b0, 3'd0, 1'b1, i[0]);
            wait_drain();
        end
        for (int i = 0; i < n_mul_group; i++) begin
            drive_cycle(1'b0, 3'd0, 1'b1, next_rand() >> 31);
        end
        wait_drain();
        report_test("multiply");

        for (int i = 0; i < mixed_cycles; i++) begin
            drive_cycle(next_rand() >> 31, 3'((next_rand() >> 8) % 7),
                        next_rand() >> 31, next_rand() >> 31);
        end
        wait_drain();
        report_test("mixed");

        in_burst = 1'b1;
        for (int i = 0; i < burst_cycles; i++) begin
            drive_cycle(1'b1, 3'((next_rand() >> 8) % 7), 1'b1, next_rand() >> 31);
        end
        check_credits("issue credits in burst", credits, 0);
        drive_cycle(1'b0, 3'd0, 1'b0, 1'b0);
        // last ALU entry leaves the bus two edges later.
        repeat (2) @(posedge clk);
        #1 in_burst = 1'b0;
        wait_drain();
        check_credits("issue credits after drain", credits, wb_pkg::mul_queue_depth);
        report_test("back_pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
design/wb_pkg.sv
design/alu_lane.sv
design/mul_unit.sv
design/wb_merge.sv
design/exec_wb_top.sv
dv/exec_wb_tb.sv
